// File: files.f
+incdir+logic
logic/mips_pkg.sv
logic/control_unit.sv
logic/cycle_sequencer.sv
logic/mult_unit.sv
logic/alu.sv
logic/register_file.sv
logic/mips_core.sv
test/mips_core_assert.sv
test/mips_core_tb.sv

// File: logic/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
	input mips_pkg::word_t a,
	input mips_pkg::word_t b,
	input logic [4:0] shamt,
	input mips_pkg::alu_func_t func,
	input mips_pkg::word_t hi,
	input mips_pkg::word_t lo,
	output mips_pkg::word_t result,
	output logic zero
);

	always_comb begin
		case (func)
			6'b100000, 6'b100001: begin
				result = a + b;
			end
			6'b100010, 6'b100011: begin
				result = a - b;
			end
			6'b100100: begin
				result = a & b;
			end
			6'b100101: begin
				result = a | b;
			end
			6'b100110: begin
				result = a ^ b;
			end
			6'b101010: begin	// Signed compare
				result = {31'd0, $signed(a) < $signed(b)};
			end
			6'b000000: begin
				result = b << shamt;
			end
			6'b000010: begin
				result = b >> shamt;
			end
			6'b101100: begin	// LUI
				result = {b[15:0], 16'd0};
			end
			6'b111110: begin
				result = lo;
			end
			6'b111111: begin
				result = hi;
			end
			default: begin
				result = '0;
			end
		endcase
	end

	assign zero = (result == '0);	// BEQ/BNE decision

endmodule

`default_nettype wire

// File: logic/control_unit.sv
`timescale 1ns/1ns
`default_nettype none

module control_unit (
	input mips_pkg::word_t instruction,
	output mips_pkg::ctrl_t ctrl
);
	import mips_pkg::*;

	logic [5:0] op;
	alu_func_t funct;

	always_comb begin
		op = instruction[31:26];
		funct = instruction[5:0];
		ctrl = '0;	// Anything unlisted is a no-op
		case (op)
			6'b000000: begin	// R-type
				ctrl.register_destination = 2'd1;
				ctrl.ALU_function = funct;
				case (funct)
					6'b100001, 6'b100011, 6'b100100, 6'b100101,
					6'b100110, 6'b101010, 6'b000000, 6'b000010: begin
						ctrl.register_write = 1'b1;
					end
					6'b001000: begin	// JR
						ctrl.jump_register = 1'b1;
					end
					6'b001001: begin	// JALR
						ctrl.register_write = 1'b1;
						ctrl.jump_register = 1'b1;
						ctrl.link = 1'b1;
					end
					6'b011001: begin	// MULTU
						ctrl.mult_start = 1'b1;
					end
					6'b010000: begin	// MFHI
						ctrl.register_write = 1'b1;
						ctrl.using_HI_LO = 1'b1;
						ctrl.ALU_function = 6'b111111;
					end
					6'b010010: begin	// MFLO
						ctrl.register_write = 1'b1;
						ctrl.using_HI_LO = 1'b1;
						ctrl.ALU_function = 6'b111110;
					end
					default: begin
						ctrl = '0;
					end
				endcase
			end
			6'b000010: begin	// J
				ctrl.jump_target = 1'b1;
			end
			6'b000011: begin	// JAL
				ctrl.register_write = 1'b1;
				ctrl.register_destination = 2'd2;
				ctrl.jump_target = 1'b1;
				ctrl.link = 1'b1;
			end
			6'b000100: begin	// BEQ
				ctrl.branch = 1'b1;
				ctrl.ALU_function = 6'b100011;
			end
			6'b000101: begin	// BNE
				ctrl.branch = 1'b1;
				ctrl.branch_not_equal = 1'b1;
				ctrl.ALU_function = 6'b100011;
			end
			6'b001000, 6'b001001: begin	// ADDI runs as ADDIU
				ctrl.register_write = 1'b1;
				ctrl.ALU_src_B = 2'd1;
				ctrl.ALU_function = 6'b100001;
			end
			6'b001010: begin	// SLTI
				ctrl.register_write = 1'b1;
				ctrl.ALU_src_B = 2'd1;
				ctrl.ALU_function = 6'b101010;
			end
			6'b001100: begin	// ANDI
				ctrl.register_write = 1'b1;
				ctrl.ALU_src_B = 2'd2;
				ctrl.ALU_function = 6'b100100;
			end
			6'b001101: begin	// ORI
				ctrl.register_write = 1'b1;
				ctrl.ALU_src_B = 2'd2;
				ctrl.ALU_function = 6'b100101;
			end
			6'b001110: begin	// XORI
				ctrl.register_write = 1'b1;
				ctrl.ALU_src_B = 2'd2;
				ctrl.ALU_function = 6'b100110;
			end
			6'b001111: begin	// LUI
				ctrl.register_write = 1'b1;
				ctrl.ALU_src_B = 2'd2;
				ctrl.ALU_function = 6'b101100;
			end
			6'b100011: begin	// LW
				ctrl.register_write = 1'b1;
				ctrl.memory_to_register = 1'b1;
				ctrl.memory_read = 1'b1;
				ctrl.ALU_src_B = 2'd1;
				ctrl.ALU_function = 6'b100001;
			end
			6'b101011: begin	// SW
				ctrl.memory_write = 1'b1;
				ctrl.ALU_src_B = 2'd1;
				ctrl.ALU_function = 6'b100001;
			end
			default: begin
				ctrl = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: logic/cycle_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module cycle_sequencer (
	input logic clk,
	input logic reset,
	input mips_pkg::ctrl_t ctrl,
	input logic wb_ack,
	input logic mult_busy,
	output mips_pkg::seq_state_t state,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output logic ir_load,
	output logic pc_load,
	output logic mdr_load,
	output logic reg_write_en,
	output logic mult_start
);
	import mips_pkg::*;

	seq_state_t next_state;
	logic bus_phase;

	always_comb begin
		next_state = state;
		case (state)
			S_FETCH: begin
				if (wb_stb && wb_ack) begin
					next_state = S_DECODE;
				end
			end
			S_DECODE: begin
				next_state = S_EXECUTE;
			end
			S_EXECUTE: begin
				if (ctrl.memory_read || ctrl.memory_write) begin
					next_state = S_MEMORY;
				end else if (ctrl.mult_start) begin
					next_state = S_MULT_WAIT;
				end else begin
					next_state = S_WRITEBACK;
				end
			end
			S_MEMORY: begin
				if (wb_stb && wb_ack) begin
					next_state = S_WRITEBACK;
				end
			end
			S_MULT_WAIT: begin
				if (!mult_busy) begin	// HI/LO valid now
					next_state = S_WRITEBACK;
				end
			end
			default: begin
				next_state = S_FETCH;
			end
		endcase
	end

	assign bus_phase = (next_state == S_FETCH) || (next_state == S_MEMORY);

	// Strobes registered so they drop on the edge after ack
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_FETCH;
			wb_cyc <= 1'b0;
			wb_stb <= 1'b0;
			wb_we <= 1'b0;
		end else begin
			state <= next_state;
			wb_cyc <= bus_phase;
			wb_stb <= bus_phase;
			wb_we <= (next_state == S_MEMORY) && ctrl.memory_write;
		end
	end

	assign ir_load = (state == S_FETCH) && wb_stb && wb_ack;
	assign mdr_load = (state == S_MEMORY) && wb_stb && wb_ack && ctrl.memory_read;
	assign mult_start = (state == S_EXECUTE) && ctrl.mult_start;
	assign reg_write_en = (state == S_WRITEBACK) && ctrl.register_write;
	assign pc_load = (state == S_WRITEBACK);	// Once per instruction

endmodule

`default_nettype wire

// File: logic/mips_core.sv
`timescale 1ns/1ns
`default_nettype none
`include "mips_params.svh"

module mips_core (
	input logic clk,
	input logic reset,
	input mips_pkg::word_t wb_dat_r,
	input logic wb_ack,
	output mips_pkg::wb_master_t wb_out
);
	import mips_pkg::*;

	word_t pc, ir, mdr;
	ctrl_t ctrl;
	seq_state_t state;
	logic wb_cyc, wb_stb, wb_we;
	logic ir_load, pc_load, mdr_load, reg_write_en, mult_start, mult_busy;
	word_t hi, lo, rs_data, rt_data, alu_b, alu_result;
	logic alu_zero, branch_taken;
	reg_addr_t wr_addr;
	word_t wr_data, sign_imm, zero_imm, pc_plus4, branch_target, jump_addr, next_pc;

	control_unit u_ctrl (.instruction(ir), .ctrl(ctrl));

	cycle_sequencer u_seq (
		.clk(clk), .reset(reset), .ctrl(ctrl), .wb_ack(wb_ack), .mult_busy(mult_busy),
		.state(state), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.ir_load(ir_load), .pc_load(pc_load), .mdr_load(mdr_load),
		.reg_write_en(reg_write_en), .mult_start(mult_start)
	);

	register_file u_regs (
		.clk(clk), .reset(reset), .rs_addr(ir[25:21]), .rt_addr(ir[20:16]),
		.wr_addr(wr_addr), .wr_en(reg_write_en), .wr_data(wr_data),
		.rs_data(rs_data), .rt_data(rt_data)
	);

	mult_unit u_mult (
		.clk(clk), .reset(reset), .start(mult_start), .multiplicand(rs_data),
		.multiplier(rt_data), .busy(mult_busy), .hi(hi), .lo(lo)
	);

	alu u_alu (
		.a(rs_data), .b(alu_b), .shamt(ir[10:6]), .func(ctrl.ALU_function),
		.hi(hi), .lo(lo), .result(alu_result), .zero(alu_zero)
	);

	assign sign_imm = {{16{ir[15]}}, ir[15:0]};
	assign zero_imm = {16'd0, ir[15:0]};
	assign pc_plus4 = pc + 32'd4;
	assign branch_target = pc_plus4 + {sign_imm[29:0], 2'b00};	// No delay slot
	assign jump_addr = {pc_plus4[31:28], ir[25:0], 2'b00};
	assign branch_taken = ctrl.branch && (alu_zero ^ ctrl.branch_not_equal);

	always_comb begin
		case (ctrl.ALU_src_B)
			2'd0: alu_b = rt_data;
			2'd1: alu_b = sign_imm;
			default: alu_b = zero_imm;
		endcase
		case (ctrl.register_destination)
			2'd0: wr_addr = ir[20:16];
			2'd1: wr_addr = ir[15:11];
			default: wr_addr = 5'd31;
		endcase
		if (ctrl.link) begin
			wr_data = pc_plus4;	// Return address
		end else if (ctrl.memory_to_register) begin
			wr_data = mdr;
		end else begin
			wr_data = alu_result;
		end
		if (ctrl.jump_register) begin
			next_pc = rs_data;
		end else if (ctrl.jump_target) begin
			next_pc = jump_addr;
		end else if (branch_taken) begin
			next_pc = branch_target;
		end else begin
			next_pc = pc_plus4;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= `MIPS_RESET_PC;
		end else if (pc_load) begin
			pc <= next_pc;
		end
	end

	always_ff @(posedge clk) begin
		if (ir_load) begin
			ir <= wb_dat_r;
		end
		if (mdr_load) begin
			mdr <= wb_dat_r;
		end
	end

	always_comb begin
		wb_out.cyc = wb_cyc;
		wb_out.stb = wb_stb;
		wb_out.we = wb_we;
		wb_out.adr = (state == S_MEMORY) ? alu_result : pc;	// Data or fetch address
		wb_out.dat_w = rt_data;
	end

endmodule

`default_nettype wire

// File: logic/mips_params.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// First fetch address
`define MIPS_RESET_PC 32'h0

// Shift-and-add steps per MULTU
`define MIPS_MULT_STEPS 32

`define MIPS_NUM_REGS 32

`endif

// File: logic/mips_pkg.sv
`default_nettype none

package mips_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [5:0] alu_func_t;	// Funct encoding, 111110 = LO, 111111 = HI
	typedef logic [1:0] reg_dest_t;	// 0 rt, 1 rd, 2 r31
	typedef logic [1:0] src_b_t;	// 0 reg, 1 sign imm, 2 zero imm

	typedef struct packed {
		logic register_write;
		logic memory_to_register;
		logic memory_write;
		logic memory_read;
		src_b_t ALU_src_B;
		reg_dest_t register_destination;
		logic branch;
		logic branch_not_equal;
		logic jump_target;	// J, JAL
		logic jump_register;	// JR, JALR
		logic link;	// Write PC+4
		logic mult_start;
		logic using_HI_LO;
		alu_func_t ALU_function;
	} ctrl_t;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		word_t adr;
		word_t dat_w;
	} wb_master_t;

	typedef enum logic [2:0] {
		S_FETCH,
		S_DECODE,
		S_EXECUTE,
		S_MEMORY,
		S_MULT_WAIT,
		S_WRITEBACK
	} seq_state_t;

endpackage

`default_nettype wire

// File: logic/mult_unit.sv
`timescale 1ns/1ns
`default_nettype none
`include "mips_params.svh"

module mult_unit (
	input logic clk,
	input logic reset,
	input logic start,
	input mips_pkg::word_t multiplicand,
	input mips_pkg::word_t multiplier,
	output logic busy,
	output mips_pkg::word_t hi,
	output mips_pkg::word_t lo
);
	import mips_pkg::*;

	logic [63:0] prod;	// Partial sum over shifted multiplier
	word_t mcand;
	logic [5:0] step_count;
	logic [32:0] partial;
	logic [63:0] prod_next;

	always_comb begin
		partial = {1'b0, prod[63:32]} + (prod[0] ? {1'b0, mcand} : 33'd0);
		prod_next = {partial, prod[31:1]};
	end

	assign busy = (step_count != 6'd0);

	always_ff @(posedge clk) begin
		if (reset) begin
			step_count <= 6'd0;
		end else if (start) begin
			step_count <= 6'(`MIPS_MULT_STEPS);
		end else if (busy) begin
			step_count <= step_count - 6'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			prod <= {32'd0, multiplier};
			mcand <= multiplicand;
		end else if (busy) begin
			prod <= prod_next;
			if (step_count == 6'd1) begin	// Last step
				hi <= prod_next[63:32];
				lo <= prod_next[31:0];
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/register_file.sv
`timescale 1ns/1ns
`default_nettype none
`include "mips_params.svh"

module register_file (
	input logic clk,
	input logic reset,
	input mips_pkg::reg_addr_t rs_addr,
	input mips_pkg::reg_addr_t rt_addr,
	input mips_pkg::reg_addr_t wr_addr,
	input logic wr_en,
	input mips_pkg::word_t wr_data,
	output mips_pkg::word_t rs_data,
	output mips_pkg::word_t rt_data
);
	import mips_pkg::*;

	word_t regs [`MIPS_NUM_REGS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && (wr_addr != 5'd0)) begin	// r0 stays zero
			regs[wr_addr] <= wr_data;
		end
	end

	assign rs_data = (rs_addr == 5'd0) ? '0 : regs[rs_addr];
	assign rt_data = (rt_addr == 5'd0) ? '0 : regs[rt_addr];

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -Wno-fatal \
	--top-module mips_core_tb -f files.f -o mips_core_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/mips_core_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "Simulator exited with status $sim_status"
	exit 1
fi

if grep -q "^Simulation PASSED$" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// File: test/mips_core_assert.sv
`timescale 1ns/1ns
`default_nettype none
`include "mips_params.svh"

module mips_core_assert (
	input logic clk,
	input logic reset,
	input mips_pkg::wb_master_t wb_out,
	input logic wb_ack,
	input logic mult_busy
);
	int busy_run;	// Busy cycles seen so far in this multiply

	always_ff @(posedge clk) begin
		if (reset || !mult_busy) begin
			busy_run <= 0;
		end else begin
			busy_run <= busy_run + 1;
		end
	end

	a_stb_needs_cyc: assert property (@(posedge clk) disable iff (reset)
		wb_out.stb |-> wb_out.cyc) else $error("stb high without cyc");

	a_req_stable: assert property (@(posedge clk) disable iff (reset)
		(wb_out.stb && !wb_ack) |=> ($stable(wb_out.adr) && $stable(wb_out.we)))
		else $error("address or we changed while waiting for ack");

	a_cyc_reset: assert property (@(posedge clk) reset |=> !wb_out.cyc)
		else $error("cyc high after a reset cycle");

	a_mult_len: assert property (@(posedge clk) disable iff (reset)
		mult_busy |-> (busy_run < `MIPS_MULT_STEPS))
		else $error("multiplier busy for too many cycles");

endmodule

bind mips_core mips_core_assert u_assert (
	.clk(clk), .reset(reset), .wb_out(wb_out), .wb_ack(wb_ack), .mult_busy(mult_busy)
);

`default_nettype wire

// File: test/mips_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module mips_core_tb;
	import mips_pkg::*;

	localparam int NUM_PROGS = 20;
	localparam int BODY_END = 133;	// First word of the register dump
	localparam int CYCLE_LIMIT = NUM_PROGS * 200 * (40 + 2 * 4);
	localparam logic [5:0] ALU_FUNCS [6] = '{6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h2a};
	localparam logic [5:0] IMM_OPS [5] = '{6'h09, 6'h0a, 6'h0c, 6'h0d, 6'h0e};

	logic clk = 1'b0;
	logic reset;
	word_t wb_dat_r;
	logic wb_ack;
	wb_master_t wb_out;

	word_t image [1024];
	word_t mem [1024];
	word_t ref_mem [1024];
	word_t exp_adr [$];
	word_t exp_dat [$];
	string test_name;
	int delay_left;
	int cycle_count = 0;

	mips_core dut0 (.clk(clk), .reset(reset), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.wb_out(wb_out));

	always #4 clk = ~clk;

	function automatic word_t enc_r(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [4:0] sh, input logic [5:0] fn);
		return {6'h00, rs, rt, rd, sh, fn};
	endfunction

	function automatic word_t enc_i(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t enc_j(input logic [5:0] op, input logic [25:0] target);
		return {op, target};
	endfunction

	// Random forward-only program followed by a dump of r1..r31, HI and LO
	task automatic build_program(input int prog);
		int idx;
		int t;
		logic [4:0] ra;
		logic [4:0] rb;
		logic [4:0] rc;
		bit landing [1024];
		for (int a = 0; a < 1024; a++) begin
			image[a] = (a * 32'h9e37_79b9) ^ {prog[15:0], 16'h5a5a};
			landing[a] = 1'b0;
		end
		image[0] = enc_r(5'd0, 5'd0, 5'd0, 5'd0, 6'h19);	// HI/LO start at zero
		for (int r = 1; r < 32; r++) begin
			image[2 * r - 1] = enc_i(6'h0f, 5'd0, 5'(r), 16'($urandom));
			image[2 * r] = enc_i(6'h0d, 5'(r), 5'(r), 16'($urandom));
		end
		idx = 63;
		while (idx < BODY_END) begin
			ra = 5'($urandom_range(0, 31));
			rb = 5'($urandom_range(0, 31));
			rc = 5'($urandom_range(0, 31));
			t = idx + 1 + $urandom_range(0, 3);
			if (t > BODY_END) begin
				t = BODY_END;
			end
			case ($urandom_range(0, 12))
				0: image[idx] = enc_r(ra, rb, rc, 5'd0, ALU_FUNCS[$urandom_range(0, 5)]);
				1: image[idx] = enc_r(5'd0, rb, rc, 5'($urandom),
					$urandom_range(0, 1) ? 6'h00 : 6'h02);
				2: image[idx] = enc_i(IMM_OPS[$urandom_range(0, 4)], ra, rb, 16'($urandom));
				3: image[idx] = enc_i(6'h0f, 5'd0, rb, 16'($urandom));
				4: image[idx] = enc_i(6'h23, 5'd0, rb, 16'(32'h800 + 4 * $urandom_range(0, 447)));
				5: image[idx] = enc_i(6'h2b, 5'd0, rb, 16'(32'h800 + 4 * $urandom_range(0, 447)));
				6, 7: begin	// Equal operands half the time
					if ($urandom_range(0, 1) == 1) begin
						rb = ra;
					end
					landing[t] = 1'b1;
					image[idx] = enc_i($urandom_range(0, 1) ? 6'h04 : 6'h05, ra, rb,
						16'(t - idx - 1));
				end
				8: begin
					landing[t] = 1'b1;
					image[idx] = enc_j($urandom_range(0, 1) ? 6'h02 : 6'h03, 26'(t));
				end
				9: begin	// ORI r29 then JR or JALR with no jump into the pair
					if ((idx + 2 <= BODY_END) && !landing[idx + 1]) begin
						t = idx + 2 + $urandom_range(0, 3);
						if (t > BODY_END) begin
							t = BODY_END;
						end
						landing[t] = 1'b1;
						image[idx] = enc_i(6'h0d, 5'd0, 5'd29, 16'(t * 4));
						idx++;
						image[idx] = $urandom_range(0, 1) ?
							enc_r(5'd29, 5'd0, 5'd0, 5'd0, 6'h08) :
							enc_r(5'd29, 5'd0, 5'($urandom_range(1, 28)), 5'd0, 6'h09);
					end else begin
						image[idx] = enc_i(6'h09, ra, rb, 16'($urandom));
					end
				end
				10: image[idx] = enc_r(ra, rb, 5'd0, 5'd0, 6'h19);
				11: image[idx] = enc_r(5'd0, 5'd0, rc, 5'd0,
					$urandom_range(0, 1) ? 6'h10 : 6'h12);
				default: image[idx] = $urandom_range(0, 1) ? {6'h3f, 26'($urandom)} :
					enc_r(ra, rb, rc, 5'd0, 6'h3f);	// Undefined
			endcase
			idx++;
		end
		for (int r = 1; r < 32; r++) begin
			image[BODY_END + r - 1] = enc_i(6'h2b, 5'd0, 5'(r), 16'(32'hf00 + 4 * r));
		end
		image[BODY_END + 31] = enc_r(5'd0, 5'd0, 5'd1, 5'd0, 6'h10);
		image[BODY_END + 32] = enc_i(6'h2b, 5'd0, 5'd1, 16'hf80);
		image[BODY_END + 33] = enc_r(5'd0, 5'd0, 5'd1, 5'd0, 6'h12);
		image[BODY_END + 34] = enc_i(6'h2b, 5'd0, 5'd1, 16'hf84);
		image[BODY_END + 35] = enc_j(6'h02, 26'(BODY_END + 35));
	endtask

	// ISA model that runs until a jump to itself and fills the expected store list
	function automatic void run_reference();
		word_t r [32];
		word_t hi_v;
		word_t lo_v;
		word_t pc;
		word_t nxt;
		word_t ins;
		word_t wv;
		word_t sext;
		word_t addr;
		logic [63:0] prod;
		logic [4:0] wr;
		logic [4:0] rs;
		logic [4:0] rt;
		int steps;
		bit done;
		for (int i = 0; i < 32; i++) begin
			r[i] = '0;
		end
		hi_v = '0;
		lo_v = '0;
		pc = '0;
		steps = 0;
		done = 1'b0;
		while (!done && steps < 2000) begin
			ins = ref_mem[pc[11:2]];
			rs = ins[25:21];
			rt = ins[20:16];
			sext = {{16{ins[15]}}, ins[15:0]};
			addr = r[rs] + sext;
			nxt = pc + 32'd4;
			wr = 5'd0;
			wv = '0;
			case (ins[31:26])
				6'h00: begin
					wr = ins[15:11];
					case (ins[5:0])
						6'h21: wv = r[rs] + r[rt];
						6'h23: wv = r[rs] - r[rt];
						6'h24: wv = r[rs] & r[rt];
						6'h25: wv = r[rs] | r[rt];
						6'h26: wv = r[rs] ^ r[rt];
						6'h2a: wv = ($signed(r[rs]) < $signed(r[rt])) ? 32'd1 : 32'd0;
						6'h00: wv = r[rt] << ins[10:6];
						6'h02: wv = r[rt] >> ins[10:6];
						6'h10: wv = hi_v;
						6'h12: wv = lo_v;
						6'h09: begin
							wv = pc + 32'd4;
							nxt = r[rs];
						end
						6'h08: begin
							wr = 5'd0;
							nxt = r[rs];
						end
						6'h19: begin
							wr = 5'd0;
							prod = {32'd0, r[rs]} * {32'd0, r[rt]};
							hi_v = prod[63:32];
							lo_v = prod[31:0];
						end
						default: wr = 5'd0;
					endcase
				end
				6'h02, 6'h03: begin
					nxt = {nxt[31:28], ins[25:0], 2'b00};
					done = (nxt == pc);
					if (ins[26]) begin	// JAL
						wr = 5'd31;
						wv = pc + 32'd4;
					end
				end
				6'h04: nxt = (r[rs] == r[rt]) ? nxt + {sext[29:0], 2'b00} : nxt;
				6'h05: nxt = (r[rs] != r[rt]) ? nxt + {sext[29:0], 2'b00} : nxt;
				6'h09: {wr, wv} = {rt, addr};
				6'h0a: {wr, wv} = {rt, ($signed(r[rs]) < $signed(sext)) ? 32'd1 : 32'd0};
				6'h0c: {wr, wv} = {rt, r[rs] & {16'd0, ins[15:0]}};
				6'h0d: {wr, wv} = {rt, r[rs] | {16'd0, ins[15:0]}};
				6'h0e: {wr, wv} = {rt, r[rs] ^ {16'd0, ins[15:0]}};
				6'h0f: {wr, wv} = {rt, ins[15:0], 16'd0};
				6'h23: {wr, wv} = {rt, ref_mem[addr[11:2]]};
				6'h2b: begin
					ref_mem[addr[11:2]] = r[rt];
					exp_adr.push_back(addr);
					exp_dat.push_back(r[rt]);
				end
				default: wr = 5'd0;
			endcase
			if (wr != 5'd0) begin
				r[wr] = wv;
			end
			pc = nxt;
			steps++;
		end
	endfunction

	// Memory slave with 0 to 3 cycles of ack delay
	always @(negedge clk) begin
		if (reset || wb_ack) begin
			wb_ack = 1'b0;
			delay_left = -1;
		end else if (wb_out.cyc && wb_out.stb) begin
			if (delay_left < 0) begin
				delay_left = $urandom_range(0, 3);
			end
			if (delay_left == 0) begin
				wb_ack = 1'b1;
				if (wb_out.we) begin
					mem[wb_out.adr[11:2]] = wb_out.dat_w;
				end else begin
					wb_dat_r = mem[wb_out.adr[11:2]];
				end
			end else begin
				delay_left--;
			end
		end
	end

	// Every acked write against the next expected store
	always @(posedge clk) begin
		if (!reset && wb_out.cyc && wb_out.stb && wb_out.we && wb_ack) begin
			assert (exp_adr.size() != 0) else begin
				$display("%s: store to %h when no store was expected", test_name, wb_out.adr);
				$display("Simulation FAILED");
				$fatal(1);
			end
			assert ({wb_out.adr, wb_out.dat_w} == {exp_adr[0], exp_dat[0]}) else begin
				$display("Mismatch %s: expected [%h]=%h, actual [%h]=%h", test_name,
					exp_adr[0], exp_dat[0], wb_out.adr, wb_out.dat_w);
				$display("Simulation FAILED");
				$fatal(1);
			end
			void'(exp_adr.pop_front());
			void'(exp_dat.pop_front());
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout: core stopped issuing stores");
			$display("Simulation FAILED");
			$fatal(1);
		end
	end

	initial begin
		reset = 1'b1;
		wb_ack = 1'b0;
		wb_dat_r = '0;
		delay_left = -1;
		void'($urandom(32'h6b96_102e));
		for (int p = 0; p < NUM_PROGS; p++) begin
			reset = 1'b1;
			test_name = $sformatf("program_%0d", p);
			build_program(p);
			for (int a = 0; a < 1024; a++) begin
				mem[a] = image[a];
				ref_mem[a] = image[a];
			end
			exp_adr.delete();
			exp_dat.delete();
			run_reference();
			repeat (4) @(negedge clk);
			reset = 1'b0;
			while (exp_adr.size() != 0) begin
				@(negedge clk);
			end
			repeat (50) @(negedge clk);	// Core spins on the final self jump with no further store
		end
		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire
